//--- src/pattern_pkg.sv
package pattern_pkg;

	// frame format
	localparam int img_width = 320;
	localparam int img_height = 240;

	// bar geometry
	localparam int bar_width = 40; // eight bars across a row
	localparam int bar_width_mini = 10; // the narrow greys in the lower band

	// first rows of the middle and lower bands
	localparam int band_mid_row = 120;
	localparam int band_low_row = 180;

	// red, green, blue in the upper three bytes, low byte unused
	typedef logic [31:0] pixel_t;

	typedef logic [17:0] addr_t; // frame buffer word address
	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;

	typedef enum logic [1:0] {
		idle,
		scan,
		finish
	} scan_state_t;

	localparam pixel_t light_gray = 32'hc0c0c000;
	localparam pixel_t yellow = 32'hc0c00000;
	localparam pixel_t light_blue = 32'h00c0c000;
	localparam pixel_t green = 32'h00c00000;
	localparam pixel_t purple = 32'hc000c000;
	localparam pixel_t red = 32'hc0000000;
	localparam pixel_t blue = 32'h0000c000;
	localparam pixel_t gray = 32'h13131300;
	localparam pixel_t dark_blue = 32'h00214c00;
	localparam pixel_t white = 32'hffffff00;
	localparam pixel_t dark_purple = 32'h32006a00;
	localparam pixel_t mid_gray1 = 32'h09090900;
	localparam pixel_t mid_gray2 = 32'h1d1d1d00;

endpackage

//--- src/stream_if.sv
// coordinate stream from the scanner to the colour stage
interface coord_if
	import pattern_pkg::*;
();
	logic valid;
	logic ready;
	x_t x;
	y_t y;

	modport src (
		output valid,
		output x,
		output y,
		input ready
	);

	modport dst (
		input valid,
		input x,
		input y,
		output ready
	);
endinterface

// coloured pixel with its coordinate, colour stage to writer
interface pixel_if
	import pattern_pkg::*;
();
	logic valid;
	logic ready;
	x_t x;
	y_t y;
	pixel_t color;

	modport src (
		output valid,
		output x,
		output y,
		output color,
		input ready
	);

	modport dst (
		input valid,
		input x,
		input y,
		input color,
		output ready
	);
endinterface

//--- src/raster_scan.sv
module raster_scan
	import pattern_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic last_written,
	output logic busy,
	output logic done,
	coord_if.src out
);

	scan_state_t state;
	x_t x;
	y_t y;
	logic fire;
	logic row_end;
	logic frame_end;

	assign fire = out.valid && out.ready;
	assign row_end = (x == x_t'(img_width - 1));
	assign frame_end = row_end && (y == y_t'(img_height - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			x <= '0;
			y <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				idle: begin
					// a start pulse is only seen here, so mid-frame starts fall away
					if (start) begin
						state <= scan;
						x <= '0;
						y <= '0;
						done <= 1'b0;
					end
				end

				scan: begin
					if (fire) begin
						if (frame_end) begin
							state <= finish; // every coordinate issued
						end else if (row_end) begin
							x <= '0;
							y <= y + 1'b1;
						end else begin
							x <= x + 1'b1;
						end
					end
				end

				finish: begin
					// wait for the pipeline to drain the last pixel
					if (last_written) begin
						state <= idle;
						done <= 1'b1;
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

	assign out.valid = (state == scan);
	assign out.x = x;
	assign out.y = y;

	assign busy = (state != idle);

endmodule

//--- src/bar_color.sv
module bar_color
	import pattern_pkg::*;
(
	input logic clk,
	input logic reset,
	coord_if.dst in,
	pixel_if.src out
);

	logic [2:0] bar_idx;
	logic [1:0] mini_idx;
	logic take;
	pixel_t color;

	// upper band, the classic eight bars
	function automatic pixel_t top_color(input logic [2:0] bar);
		case (bar)
			3'd0: return light_gray;
			3'd1: return yellow;
			3'd2: return light_blue;
			3'd3: return green;
			3'd4: return purple;
			3'd5: return red;
			3'd6: return blue;
			default: return white;
		endcase
	endfunction

	// middle band, odd bars are all gray
	function automatic pixel_t mid_color(input logic [2:0] bar);
		case (bar)
			3'd0: return blue;
			3'd2: return purple;
			3'd4: return light_blue;
			3'd6: return light_gray;
			default: return gray;
		endcase
	endfunction

	// lower band, bar 4 is cut into four narrow greys
	function automatic pixel_t low_color(input logic [2:0] bar, input logic [1:0] mini);
		case (bar)
			3'd0: return dark_blue;
			3'd1: return white;
			3'd2: return dark_purple;
			3'd4: begin
				case (mini)
					2'd0: return mid_gray1;
					2'd1: return gray;
					2'd2: return mid_gray2;
					default: return mid_gray1;
				endcase
			end
			3'd6: return light_gray;
			default: return gray;
		endcase
	endfunction

	always_comb begin
		bar_idx = 3'(in.x / x_t'(bar_width));
		// only meaningful inside bar 4
		mini_idx = 2'((in.x - x_t'(4 * bar_width)) / x_t'(bar_width_mini));

		if (in.y < y_t'(band_mid_row)) begin
			color = top_color(bar_idx);
		end else if (in.y < y_t'(band_low_row)) begin
			color = mid_color(bar_idx);
		end else begin
			color = low_color(bar_idx, mini_idx);
		end
	end

	// accept when empty or when the held pixel leaves this cycle
	assign in.ready = !out.valid || out.ready;
	assign take = in.valid && in.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (take) begin
			out.valid <= 1'b1;
		end else if (out.ready) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.x <= in.x;
			out.y <= in.y;
			out.color <= color;
		end
	end

endmodule

//--- src/frame_writer.sv
module frame_writer
	import pattern_pkg::*;
(
	input logic clk,
	input logic reset,
	input addr_t base_addr,
	pixel_if.dst in,
	output addr_t mem_addr,
	output pixel_t mem_data,
	output logic mem_valid,
	input logic mem_ready,
	output logic last_written
);

	addr_t row_base;
	logic in_last;
	logic held_last;
	logic take;

	// wraps modulo 2^18 by the width of addr_t
	assign row_base = base_addr + addr_t'(in.y) * addr_t'(img_width);

	// final coordinate of the frame
	assign in_last = (in.x == x_t'(img_width - 1)) && (in.y == y_t'(img_height - 1));

	assign in.ready = !mem_valid || mem_ready;
	assign take = in.valid && in.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid <= 1'b0;
		end else if (take) begin
			mem_valid <= 1'b1;
		end else if (mem_ready) begin
			mem_valid <= 1'b0; // write done, nothing new behind it
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			mem_addr <= row_base + addr_t'(in.x);
			mem_data <= in.color;
			held_last <= in_last;
		end
	end

	assign last_written = mem_valid && mem_ready && held_last;

endmodule

//--- src/color_bar_gen.sv
module color_bar_gen
	import pattern_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input addr_t base_addr,
	output addr_t mem_addr,
	output pixel_t mem_data,
	output logic mem_valid,
	input logic mem_ready,
	output logic done
);

	coord_if coord ();
	pixel_if pixel ();

	logic last_written; // final pixel accepted by memory

	raster_scan u_scan (
		.clk (clk),
		.reset (reset),
		.start (start),
		.last_written (last_written),
		.busy (),
		.done (done),
		.out (coord.src)
	);

	bar_color u_color (
		.clk (clk),
		.reset (reset),
		.in (coord.dst),
		.out (pixel.src)
	);

	frame_writer u_writer (
		.clk (clk),
		.reset (reset),
		.base_addr (base_addr),
		.in (pixel.dst),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.mem_valid (mem_valid),
		.mem_ready (mem_ready),
		.last_written (last_written)
	);

endmodule

//--- test/color_bar_properties.sv
module color_bar_properties
	import pattern_pkg::*;
(
	input logic clk,
	input logic reset,
	input addr_t mem_addr,
	input pixel_t mem_data,
	input logic mem_valid,
	input logic mem_ready,
	input logic done
);

	// a stalled write keeps its address and data
	hold_under_stall: assert property (@(posedge clk) disable iff (reset)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
		else $error("write port changed while mem_ready was low");

	no_done_while_writing: assert property (@(posedge clk) disable iff (reset)
		!(done && mem_valid))
		else $error("done and mem_valid high together");

	idle_after_reset: assert property (@(posedge clk) reset |=> !mem_valid)
		else $error("mem_valid high in the cycle after reset");

endmodule

//--- test/color_bar_checker.sv
module color_bar_checker
	import pattern_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic frame_begin, // restarts the pixel index
	input addr_t base_addr,
	input addr_t mem_addr,
	input pixel_t mem_data,
	input logic mem_valid,
	input logic mem_ready,
	output int write_count,
	output int error_count
);

	int cx;
	int cy;

	function automatic pixel_t colour_at(input int px, input int py);
		pixel_t top [8];
		top = '{light_gray, yellow, light_blue, green, purple, red, blue, white};
		if (py < band_mid_row) return top[px / bar_width];
		if (py < band_low_row) begin
			if ((px / bar_width) % 2 == 1) return gray;
			if (px < 40) return blue;
			if (px < 120) return purple;
			if (px < 200) return light_blue;
			return light_gray;
		end
		if (px < 40) return dark_blue;
		if (px < 80) return white;
		if (px < 120) return dark_purple;
		if (px < 160) return gray;
		if (px < 170) return mid_gray1; // narrow greys
		if (px < 180) return gray;
		if (px < 190) return mid_gray2;
		if (px < 200) return mid_gray1;
		if (px >= 240 && px < 280) return light_gray;
		return gray;
	endfunction

	always @(posedge clk) begin : compare
		int bad;
		addr_t want_addr;
		pixel_t want_data;
		bad = 0;
		if (frame_begin) begin
			write_count <= 0;
			cx <= 0;
			cy <= 0;
		end else if (!reset && mem_valid && mem_ready) begin
			want_addr = base_addr + addr_t'(write_count);
			want_data = colour_at(cx, cy);
			if (write_count >= img_width * img_height) begin
				$display("more writes than pixels in the frame at time %0t", $time);
				bad++;
			end
			if (mem_addr !== want_addr) begin
				$display("FAIL %0t mem_addr expected %h got %h", $time, want_addr, mem_addr);
				bad++;
			end
			if (mem_data !== want_data) begin
				$display("FAIL %0t mem_data expected %h got %h", $time, want_data, mem_data);
				bad++;
			end
			write_count <= write_count + 1;
			if (cx == img_width - 1) begin
				cx <= 0;
				cy <= cy + 1;
			end else begin
				cx <= cx + 1;
			end
		end
		error_count <= error_count + bad;
	end

endmodule

//--- test/color_bar_tb.sv
module color_bar_tb;
	import pattern_pkg::*;

	localparam int frame_pixels = img_width * img_height;
	localparam int cycle_limit = 5 * frame_pixels * 2 + 1000;

	logic clk = 1'b0;
	logic reset;
	logic start;
	addr_t base_addr;
	addr_t mem_addr;
	pixel_t mem_data;
	logic mem_valid;
	logic mem_ready = 1'b0;
	logic done;
	logic frame_begin;
	logic ready_random;
	logic [31:0] lcg_state = 32'h0f967d65;
	int cycles = 0;
	int fails = 0;
	int mark = 0;
	int tests_run = 0;
	int writes_seen = 0;
	int write_count;
	int error_count;
	int edges;
	int held;

	color_bar_gen UUT (
		.clk (clk),
		.reset (reset),
		.start (start),
		.base_addr (base_addr),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.mem_valid (mem_valid),
		.mem_ready (mem_ready),
		.done (done)
	);

	color_bar_checker chk (
		.clk (clk),
		.reset (reset),
		.frame_begin (frame_begin),
		.base_addr (base_addr),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.mem_valid (mem_valid),
		.mem_ready (mem_ready),
		.write_count (write_count),
		.error_count (error_count)
	);

	bind color_bar_gen color_bar_properties u_props (
		.clk (clk),
		.reset (reset),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.mem_valid (mem_valid),
		.mem_ready (mem_ready),
		.done (done)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ready about three cycles in four when random
	always @(posedge clk) begin
		lcg_state <= lcg_next(lcg_state);
		mem_ready <= ready_random ? (lcg_state[17:16] != 2'b00) : 1'b1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic pulse_start(input addr_t base, input logic fresh);
		@(posedge clk);
		base_addr <= base;
		start <= 1'b1;
		frame_begin <= fresh;
		@(posedge clk);
		start <= 1'b0;
		frame_begin <= 1'b0;
	endtask

	// edges from the start sampling edge up to the first write
	task automatic wait_first_write(output int n);
		logic is_write;
		n = 0;
		do begin
			@(negedge clk);
			is_write = mem_valid && mem_ready;
			@(posedge clk);
			n++;
		end while (!is_write);
	endtask

	task automatic wait_done(output int n);
		n = 0;
		@(negedge clk);
		while (!done) begin
			@(posedge clk);
			n++;
			@(negedge clk);
		end
	endtask

	task automatic wait_writes(input int n);
		do @(negedge clk); while (write_count < n);
	endtask

	task automatic expect_int(input string what, input int want, input int got);
		if (want != got) begin
			$display("FAIL %0t %s expected %0d got %0d", $time, what, want, got);
			fails++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		int bad;
		bad = fails + error_count - mark;
		$display("test %0d %s: %0d writes, %0d errors", num, name, write_count, bad);
		mark = fails + error_count;
		writes_seen += write_count;
		tests_run++;
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		base_addr = '0;
		frame_begin = 1'b0;
		ready_random = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		pulse_start(18'h00000, 1'b1);
		wait_first_write(edges);
		expect_int("first write latency", 3, edges);
		wait_done(edges);
		// done is set on the edge of the last write, frame_pixels - 1 edges after the first
		expect_int("cycles to done", frame_pixels - 1, edges);
		expect_int("write_count", frame_pixels, write_count);
		report_test(1, "full frame at base 0");

		@(posedge clk) ready_random <= 1'b1;
		pulse_start(18'h02000, 1'b1);
		wait_done(edges);
		expect_int("write_count", frame_pixels, write_count);
		report_test(2, "random back-pressure");

		@(posedge clk) ready_random <= 1'b0;
		pulse_start(18'h00100, 1'b1);
		wait_writes(1000);
		pulse_start(18'h00100, 1'b0); // ignored mid-frame
		wait_done(edges);
		expect_int("write_count", frame_pixels, write_count);
		held = 0;
		repeat (50) begin
			@(negedge clk);
			if (done) held++;
		end
		expect_int("cycles done held", 50, held);
		report_test(3, "done hold and mid-frame start");

		pulse_start(18'h3ff00, 1'b1); // wraps past 2^18
		@(negedge clk);
		expect_int("done", 0, done);
		wait_done(edges);
		expect_int("write_count", frame_pixels, write_count);
		report_test(4, "second frame with address wrap");

		@(posedge clk) ready_random <= 1'b1;
		pulse_start(18'h01000, 1'b1);
		wait_writes(5000);
		@(posedge clk) reset <= 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		expect_int("mem_valid", 0, mem_valid);
		expect_int("done", 0, done);
		held = write_count;
		repeat (20) @(negedge clk);
		expect_int("write_count after reset", held, write_count);
		pulse_start(18'h01000, 1'b1);
		wait_done(edges);
		expect_int("write_count", frame_pixels, write_count);
		report_test(5, "reset in mid-frame");

		$display("%0d tests, %0d writes, %0d errors", tests_run, writes_seen,
			fails + error_count);
		if (fails + error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- all.f
src/pattern_pkg.sv
src/stream_if.sv
src/raster_scan.sv
src/bar_color.sv
src/frame_writer.sv
src/color_bar_gen.sv
test/color_bar_properties.sv
test/color_bar_checker.sv
test/color_bar_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= color_bar_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG ?= TEST RESULT: FAIL
PASS_MSG ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
